//--- design/perceptron_pkg.sv
package perceptron_pkg;

  // Features per sample
  localparam int n_inputs = 2;

  // Neurons in the layer
  localparam int n_nodes = 2;

  // Feature width, also the fixed-point fraction of the weights
  localparam int data_w = 8;

  // Products, deltas and feedback terms
  localparam int value_w = 16;

  // Extra right shift on the weight update
  localparam int learn_shift = 2;

endpackage

//--- design/node.sv
`timescale 1ns/1ns

module node (
  input  logic clock,
  input  logic reset,
  input  logic train,

  input  logic operand_valid,
  input  logic [perceptron_pkg::n_inputs-1:0][perceptron_pkg::data_w-1:0] operand_data,
  output logic operand_ready,

  output logic product_valid,
  output logic [perceptron_pkg::value_w-1:0] product_data,
  input  logic product_ready,

  input  logic delta_valid,
  input  logic [perceptron_pkg::value_w-1:0] delta_data,
  output logic delta_ready,

  output logic feedback_valid,
  output logic [perceptron_pkg::n_inputs-1:0][perceptron_pkg::value_w-1:0] feedback_data,
  input  logic feedback_ready
);
  import perceptron_pkg::*;

  logic [$clog2(n_inputs)-1:0] counter;
  logic count_done;

  // Features as 9-bit signed, everything else in 18-bit signed
  logic signed [data_w:0] operand [n_inputs];
  logic signed [2*data_w+1:0] weight [n_inputs];
  logic signed [2*data_w+1:0] summand;
  logic signed [2*data_w+1:0] accumulator;
  logic signed [2*data_w+1:0] delta;
  logic [value_w-1:0] error [n_inputs];

  enum logic [3:0] {
    st_ready,
    st_multiply,
    st_accumulate,
    st_flush,
    st_product,
    st_delta,
    st_error,
    st_feedback,
    st_update
  } state;

  assign count_done = counter == ($clog2(n_inputs))'(n_inputs - 1);

  // Operand load
  assign operand_ready = state == st_ready;

  always_ff @(posedge clock) begin
    if (operand_valid && operand_ready) begin
      for (int i = 0; i < n_inputs; i++) begin
        operand[i] <= $signed({1'b0, operand_data[i]});
      end
    end
  end

  // Walks the inputs in the serial states
  always_ff @(posedge clock) begin
    if (reset) begin
      counter <= '0;
    end else if (state == st_multiply || state == st_accumulate ||
                 state == st_error || state == st_update) begin
      if (count_done) begin
        counter <= '0;
      end else begin
        counter <= counter + 1'b1;
      end
    end
  end

  // Multiply-accumulate, one input per cycle
  always_ff @(posedge clock) begin
    if (state == st_multiply || state == st_accumulate) begin
      summand <= (weight[counter] * (2 * data_w + 2)'(operand[counter])) >>> data_w;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      accumulator <= '0;
    end else if (state == st_ready) begin
      accumulator <= '0;
    end else if (state == st_accumulate || state == st_flush) begin
      accumulator <= accumulator + summand;
    end
  end

  // Product beat
  always_ff @(posedge clock) begin
    if (reset) begin
      product_valid <= 1'b0;
    end else if (state == st_product) begin
      if (!product_valid) begin
        product_valid <= 1'b1;
      end else if (product_ready) begin
        product_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_product && !product_valid) begin
      product_data <= accumulator[value_w-1:0];
    end
  end

  // Delta load, sign-extended
  assign delta_ready = state == st_delta;

  always_ff @(posedge clock) begin
    if (delta_valid && delta_ready) begin
      delta <= (2 * data_w + 2)'($signed(delta_data));
    end
  end

  // Error term per input
  always_ff @(posedge clock) begin
    if (state == st_error) begin
      error[counter] <= value_w'((weight[counter] * delta) >>> data_w);
    end
  end

  // Feedback beat
  always_ff @(posedge clock) begin
    if (reset) begin
      feedback_valid <= 1'b0;
    end else if (state == st_feedback) begin
      if (!feedback_valid) begin
        feedback_valid <= 1'b1;
      end else if (feedback_ready) begin
        feedback_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_feedback && !feedback_valid) begin
      for (int i = 0; i < n_inputs; i++) begin
        feedback_data[i] <= error[i];
      end
    end
  end

  // Weight update, delta times feature scaled down by the learn rate
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < n_inputs; i++) begin
        weight[i] <= '0;
      end
    end else if (state == st_update) begin
      weight[counter] <= weight[counter] +
        ((delta * (2 * data_w + 2)'(operand[counter])) >>> (learn_shift + data_w));
    end
  end

  // One sample at a time, inference then optional training
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_ready;
    end else begin
      case (state)
        st_ready:
          if (operand_valid) begin
            state <= st_multiply;
          end
        st_multiply:
          state <= st_accumulate;
        st_accumulate:
          if (count_done) begin
            state <= st_flush;
          end
        st_flush:
          state <= st_product;
        st_product:
          if (product_valid && product_ready) begin
            state <= train ? st_delta : st_ready;
          end
        st_delta:
          if (delta_valid && delta_ready) begin
            state <= st_error;
          end
        st_error:
          if (count_done) begin
            state <= st_feedback;
          end
        st_feedback:
          if (feedback_valid && feedback_ready) begin
            state <= st_update;
          end
        st_update:
          if (count_done) begin
            state <= st_ready;
          end
        default:
          state <= st_ready;
      endcase
    end
  end

endmodule

//--- design/layer.sv
`timescale 1ns/1ns

module layer (
  input  logic clock,
  input  logic reset,
  input  logic train,

  input  logic operand_valid,
  input  logic [perceptron_pkg::n_inputs-1:0][perceptron_pkg::data_w-1:0] operand_data,
  output logic operand_ready,

  output logic product_valid,
  output logic [perceptron_pkg::n_nodes-1:0][perceptron_pkg::value_w-1:0] product_data,
  input  logic product_ready,

  input  logic delta_valid,
  input  logic [perceptron_pkg::n_nodes-1:0][perceptron_pkg::value_w-1:0] delta_data,
  output logic delta_ready,

  output logic feedback_valid,
  output logic [perceptron_pkg::n_inputs-1:0][perceptron_pkg::value_w-1:0] feedback_data,
  input  logic feedback_ready
);
  import perceptron_pkg::*;

  logic [n_nodes-1:0] node_operand_ready;
  logic [n_nodes-1:0] node_product_valid;
  logic [n_nodes-1:0] node_product_ready;
  logic [n_nodes-1:0] node_delta_ready;
  logic [n_nodes-1:0] node_feedback_valid;
  logic [n_nodes-1:0] node_feedback_ready;
  logic [n_nodes-1:0][value_w-1:0] node_product_data;
  logic [n_nodes-1:0][n_inputs-1:0][value_w-1:0] node_feedback_data;

  // Per-neuron capture
  logic [n_nodes-1:0] product_take;
  logic [n_nodes-1:0] feedback_take;
  logic [n_nodes-1:0] product_held;
  logic [n_nodes-1:0] feedback_held;
  logic [n_nodes-1:0][value_w-1:0] product_hold;
  logic [n_nodes-1:0][n_inputs-1:0][value_w-1:0] feedback_hold;

  // Broadcast only when every neuron can take the beat
  assign operand_ready = &node_operand_ready;
  assign delta_ready = &node_delta_ready;

  for (genvar j = 0; j < n_nodes; j++) begin : gen_node
    node node0 (
      .clock          (clock),
      .reset          (reset),
      .train          (train),
      .operand_valid  (operand_valid && operand_ready),
      .operand_data   (operand_data),
      .operand_ready  (node_operand_ready[j]),
      .product_valid  (node_product_valid[j]),
      .product_data   (node_product_data[j]),
      .product_ready  (node_product_ready[j]),
      .delta_valid    (delta_valid && delta_ready),
      .delta_data     (delta_data[j]),
      .delta_ready    (node_delta_ready[j]),
      .feedback_valid (node_feedback_valid[j]),
      .feedback_data  (node_feedback_data[j]),
      .feedback_ready (node_feedback_ready[j])
    );
  end

  // A neuron is accepted once, then waits until the joined beat leaves
  assign node_product_ready = node_product_valid & ~product_held;
  assign node_feedback_ready = node_feedback_valid & ~feedback_held;
  assign product_take = node_product_valid & node_product_ready;
  assign feedback_take = node_feedback_valid & node_feedback_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      product_held <= '0;
      feedback_held <= '0;
    end else begin
      product_held <= (product_held | product_take) &
                      ~{n_nodes{product_valid && product_ready}};
      feedback_held <= (feedback_held | feedback_take) &
                       ~{n_nodes{feedback_valid && feedback_ready}};
    end
  end

  always_ff @(posedge clock) begin
    for (int j = 0; j < n_nodes; j++) begin
      if (product_take[j]) begin
        product_hold[j] <= node_product_data[j];
      end
      if (feedback_take[j]) begin
        feedback_hold[j] <= node_feedback_data[j];
      end
    end
  end

  assign product_valid = &product_held;
  assign product_data = product_hold;
  assign feedback_valid = &feedback_held;

  // Error terms summed over neurons, per input, wrapping
  always_comb begin
    for (int i = 0; i < n_inputs; i++) begin
      feedback_data[i] = '0;
      for (int j = 0; j < n_nodes; j++) begin
        feedback_data[i] = feedback_data[i] + feedback_hold[j][i];
      end
    end
  end

endmodule

//--- design/error_unit.sv
`timescale 1ns/1ns

module error_unit (
  input  logic clock,
  input  logic reset,
  input  logic train,

  input  logic product_valid,
  input  logic [perceptron_pkg::n_nodes-1:0][perceptron_pkg::value_w-1:0] product_data,
  output logic product_ready,

  output logic result_valid,
  output logic [perceptron_pkg::n_nodes-1:0][perceptron_pkg::value_w-1:0] result_data,
  input  logic result_ready,

  input  logic target_valid,
  input  logic [perceptron_pkg::n_nodes-1:0][perceptron_pkg::value_w-1:0] target_data,
  output logic target_ready,

  output logic delta_valid,
  output logic [perceptron_pkg::n_nodes-1:0][perceptron_pkg::value_w-1:0] delta_data,
  input  logic delta_ready
);
  import perceptron_pkg::*;

  logic [n_nodes-1:0][value_w-1:0] product_store;
  logic product_done;
  logic target_done;

  // Results leave unchanged
  assign result_valid = product_valid;
  assign result_data = product_data;
  assign product_ready = result_ready;

  assign product_done = product_valid && product_ready;
  assign target_done = target_valid && target_ready;

  // Products kept for the delta when training
  always_ff @(posedge clock) begin
    if (product_done && train) begin
      product_store <= product_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      target_ready <= 1'b0;
    end else if (product_done && train) begin
      target_ready <= 1'b1;
    end else if (target_done) begin
      target_ready <= 1'b0;
    end
  end

  // Delta is target minus product, wrapping
  always_ff @(posedge clock) begin
    if (target_done) begin
      for (int j = 0; j < n_nodes; j++) begin
        delta_data[j] <= target_data[j] - product_store[j];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      delta_valid <= 1'b0;
    end else if (target_done) begin
      delta_valid <= 1'b1;
    end else if (delta_valid && delta_ready) begin
      delta_valid <= 1'b0;
    end
  end

endmodule

//--- design/perceptron_top.sv
`timescale 1ns/1ns

module perceptron_top (
  input  logic clock,
  input  logic reset,
  input  logic train,

  input  logic operand_valid,
  input  logic [perceptron_pkg::n_inputs-1:0][perceptron_pkg::data_w-1:0] operand_data,
  output logic operand_ready,

  output logic result_valid,
  output logic [perceptron_pkg::n_nodes-1:0][perceptron_pkg::value_w-1:0] result_data,
  input  logic result_ready,

  input  logic target_valid,
  input  logic [perceptron_pkg::n_nodes-1:0][perceptron_pkg::value_w-1:0] target_data,
  output logic target_ready,

  output logic feedback_valid,
  output logic [perceptron_pkg::n_inputs-1:0][perceptron_pkg::value_w-1:0] feedback_data,
  input  logic feedback_ready
);
  import perceptron_pkg::*;

  logic product_valid;
  logic [n_nodes-1:0][value_w-1:0] product_data;
  logic product_ready;

  logic delta_valid;
  logic [n_nodes-1:0][value_w-1:0] delta_data;
  logic delta_ready;

  layer layer0 (
    .clock          (clock),
    .reset          (reset),
    .train          (train),
    .operand_valid  (operand_valid),
    .operand_data   (operand_data),
    .operand_ready  (operand_ready),
    .product_valid  (product_valid),
    .product_data   (product_data),
    .product_ready  (product_ready),
    .delta_valid    (delta_valid),
    .delta_data     (delta_data),
    .delta_ready    (delta_ready),
    .feedback_valid (feedback_valid),
    .feedback_data  (feedback_data),
    .feedback_ready (feedback_ready)
  );

  error_unit error0 (
    .clock         (clock),
    .reset         (reset),
    .train         (train),
    .product_valid (product_valid),
    .product_data  (product_data),
    .product_ready (product_ready),
    .result_valid  (result_valid),
    .result_data   (result_data),
    .result_ready  (result_ready),
    .target_valid  (target_valid),
    .target_data   (target_data),
    .target_ready  (target_ready),
    .delta_valid   (delta_valid),
    .delta_data    (delta_data),
    .delta_ready   (delta_ready)
  );

endmodule

//--- bench/perceptron_tb.sv
`timescale 1ns/1ns

module perceptron_tb;
  import perceptron_pkg::*;

  localparam int timeout_cycles = 200;

  logic clock;
  logic reset;
  logic train;
  logic operand_valid;
  logic [n_inputs-1:0][data_w-1:0] operand_data;
  logic operand_ready;
  logic result_valid;
  logic [n_nodes-1:0][value_w-1:0] result_data;
  logic result_ready;
  logic target_valid;
  logic [n_nodes-1:0][value_w-1:0] target_data;
  logic target_ready;
  logic feedback_valid;
  logic [n_inputs-1:0][value_w-1:0] feedback_data;
  logic feedback_ready;

  logic [31:0] rand_state;
  int sample_count;

  perceptron_top dut0 (
    .clock          (clock),
    .reset          (reset),
    .train          (train),
    .operand_valid  (operand_valid),
    .operand_data   (operand_data),
    .operand_ready  (operand_ready),
    .result_valid   (result_valid),
    .result_data    (result_data),
    .result_ready   (result_ready),
    .target_valid   (target_valid),
    .target_data    (target_data),
    .target_ready   (target_ready),
    .feedback_valid (feedback_valid),
    .feedback_data  (feedback_data),
    .feedback_ready (feedback_ready)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #5 clock = ~clock;
    end
  end

  // LCG step
  function automatic logic [31:0] next_random();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // Ready high about three cycles in four
  function automatic logic ready_draw();
    logic [31:0] word;
    word = next_random();
    return word[31:30] != 2'b00;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s expected %h actual %h", name, expected, actual);
      $display("Something failed");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Something failed");
    $fatal(1, "timed out after %0d cycles waiting for %s", timeout_cycles, what);
  endtask

  // Nothing may be pending between samples
  task automatic idle_outputs(input int n);
    check_value($sformatf("sample %0d idle result_valid", n), 32'd0, 32'(result_valid));
    check_value($sformatf("sample %0d idle feedback_valid", n), 32'd0, 32'(feedback_valid));
    check_value($sformatf("sample %0d idle target_ready", n), 32'd0, 32'(target_ready));
  endtask

  task automatic send_operand(input int n, input logic [7:0] x0, input logic [7:0] x1,
                              input logic mode);
    int cycles;
    cycles = 0;
    train = mode;
    operand_data[0] = x0;
    operand_data[1] = x1;
    operand_valid = 1'b1;
    @(negedge clock);
    idle_outputs(n);
    while (!operand_ready) begin
      if (cycles == timeout_cycles) report_timeout("operand_ready");
      cycles++;
      @(negedge clock);
      idle_outputs(n);
    end
    @(posedge clock);
    #1;
    operand_valid = 1'b0;
  endtask

  task automatic receive_result(input int n, input logic [31:0] p0, input logic [31:0] p1);
    int cycles;
    cycles = 0;
    result_ready = ready_draw();
    @(negedge clock);
    while (!(result_valid && result_ready)) begin
      check_value($sformatf("sample %0d early feedback_valid", n), 32'd0,
                  32'(feedback_valid));
      check_value($sformatf("sample %0d early target_ready", n), 32'd0, 32'(target_ready));
      if (cycles == timeout_cycles) report_timeout("the result beat");
      cycles++;
      @(posedge clock);
      #1;
      result_ready = ready_draw();
      @(negedge clock);
    end
    check_value($sformatf("sample %0d result p0", n), p0, 32'(result_data[0]));
    check_value($sformatf("sample %0d result p1", n), p1, 32'(result_data[1]));
    @(posedge clock);
    #1;
    result_ready = 1'b0;
  endtask

  task automatic send_target(input int n, input logic [15:0] t0, input logic [15:0] t1);
    int cycles;
    int gap;
    logic [31:0] word;
    cycles = 0;
    word = next_random();
    gap = int'(word[29:28]);
    repeat (gap) begin
      @(posedge clock);
      #1;
    end
    target_data[0] = t0;
    target_data[1] = t1;
    target_valid = 1'b1;
    @(negedge clock);
    while (!target_ready) begin
      if (cycles == timeout_cycles) report_timeout($sformatf("target_ready in sample %0d", n));
      cycles++;
      @(negedge clock);
    end
    @(posedge clock);
    #1;
    target_valid = 1'b0;
  endtask

  task automatic receive_feedback(input int n, input logic [31:0] f0, input logic [31:0] f1);
    int cycles;
    cycles = 0;
    feedback_ready = ready_draw();
    @(negedge clock);
    while (!(feedback_valid && feedback_ready)) begin
      check_value($sformatf("sample %0d training result_valid", n), 32'd0,
                  32'(result_valid));
      if (cycles == timeout_cycles) report_timeout("the feedback beat");
      cycles++;
      @(posedge clock);
      #1;
      feedback_ready = ready_draw();
      @(negedge clock);
    end
    check_value($sformatf("sample %0d feedback f0", n), f0, 32'(feedback_data[0]));
    check_value($sformatf("sample %0d feedback f1", n), f1, 32'(feedback_data[1]));
    @(posedge clock);
    #1;
    feedback_ready = 1'b0;
  endtask

  initial begin
    int fd;
    int code;
    string line;
    logic [31:0] c_train;
    logic [31:0] c_x0;
    logic [31:0] c_x1;
    logic [31:0] c_t0;
    logic [31:0] c_t1;
    logic [31:0] c_p0;
    logic [31:0] c_p1;
    logic [31:0] c_f0;
    logic [31:0] c_f1;

    rand_state = 32'h94bbaa45;
    sample_count = 0;
    reset = 1'b1;
    train = 1'b0;
    operand_valid = 1'b0;
    operand_data = '0;
    result_ready = 1'b0;
    target_valid = 1'b0;
    target_data = '0;
    feedback_ready = 1'b0;

    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    @(negedge clock);
    check_value("reset operand_ready", 32'd1, 32'(operand_ready));
    check_value("reset result_valid", 32'd0, 32'(result_valid));
    check_value("reset feedback_valid", 32'd0, 32'(feedback_valid));
    check_value("reset target_ready", 32'd0, 32'(target_ready));
    @(posedge clock);
    #1;

    fd = $fopen("bench/perceptron_trace.txt", "r");
    if (fd == 0) begin
      $display("Something failed");
      $fatal(1, "cannot open bench/perceptron_trace.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      // Skip comment and blank lines
      if (code != 0 && line.len() > 1 && line[0] != "#") begin
        code = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                       c_train, c_x0, c_x1, c_t0, c_t1, c_p0, c_p1, c_f0, c_f1);
        if (code != 9) begin
          $display("Something failed");
          $fatal(1, "trace line %0d does not hold nine columns", sample_count + 1);
        end
        send_operand(sample_count, c_x0[7:0], c_x1[7:0], c_train[0]);
        receive_result(sample_count, c_p0, c_p1);
        if (c_train[0]) begin
          send_target(sample_count, c_t0[15:0], c_t1[15:0]);
          receive_feedback(sample_count, c_f0, c_f1);
        end
        sample_count++;
      end
    end
    $fclose(fd);

    if (sample_count == 0) begin
      $display("Something failed");
      $fatal(1, "the trace held no samples");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

//--- perceptron.f
design/perceptron_pkg.sv
design/node.sv
design/layer.sv
design/error_unit.sv
design/perceptron_top.sv
bench/perceptron_tb.sv

//--- run_perceptron.sh
#!/bin/sh
# Compile the perceptron testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timescale 1ns/1ns --top-module perceptron_tb \
  -f perceptron.f -o perceptron_sim
./obj_dir/perceptron_sim

//--- bench/perceptron_trace.txt
# columns in hex: train x0 x1 t0 t1 p0 p1 f0 f1
# p0 p1 are the expected products, f0 f1 the expected feedback sums on training lines
0 0a 14 0000 0000 0000 0000 0000 0000
1 64 32 03e8 0200 0000 0000 0000 0000
0 40 80 0000 0000 0030 0018 0000 0000
1 c8 28 0100 0010 0052 002a 003b 001d
0 ff ff 0000 0000 00b6 0041 0000 0000
1 10 f0 0000 0100 003a 0017 000a 0007
0 80 80 0000 0000 0054 003d 0000 0000
1 00 64 fe0c 0000 000f 001e fef6 ffa5
0 14 c8 0000 0000 0001 003c 0000 0000
0 01 fa 0000 0000 fff5 0048 0000 0000
1 32 32 0000 0000 0016 0017 ffef fff9
0 64 64 0000 0000 002b 002d 0000 0000
